//--- Bender.yml
package:
  name: gw_loopback

sources:
  - include_dirs:
      - hw
    files:
      - hw/gw_pkg.sv
      - hw/gw_tag_master.sv
      - hw/gw_tag_regs.sv
      - hw/gw_link_fifo.sv
      - hw/gw_test_node.sv
      - hw/gw_loopback_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/gw_loopback_chk.sv
      - tb/tb_gw_loopback.sv

//--- compile.f
+incdir+hw
hw/gw_pkg.sv
hw/gw_tag_master.sv
hw/gw_tag_regs.sv
hw/gw_link_fifo.sv
hw/gw_test_node.sv
hw/gw_loopback_top.sv
tb/gw_loopback_chk.sv
tb/tb_gw_loopback.sv

//--- hw/gw_defines.svh
`ifndef GW_DEFINES_SVH
`define GW_DEFINES_SVH

//////////////////////////////
// Link data path
//////////////////////////////

// Word carried by the loopback link
`define GW_DATA_W 8

// Sent, received and error counters
`define GW_CNT_W 16

// Storage entries in the link FIFO
`define GW_FIFO_DEPTH 4

//////////////////////////////
// Tag line packet fields
//////////////////////////////

`define GW_TAG_ID_W 2
`define GW_TAG_PAYLOAD_W 8

// Start value of both pattern LFSRs, must not be zero
`define GW_LFSR_SEED 8'hA5

`endif

//--- hw/gw_link_fifo.sv
`timescale 1ns/10ps
`include "gw_defines.svh"

module gw_link_fifo
#(
  parameter int DEPTH = `GW_FIFO_DEPTH
)
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  push_valid_i,
  input  logic [`GW_DATA_W-1:0] push_data_i,
  output logic                  push_ready_o,
  output logic                  pop_valid_o,
  output logic [`GW_DATA_W-1:0] pop_data_o,
  input  logic                  pop_ready_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [`GW_DATA_W-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0]      wr_ptr_q;
  logic [PTR_W-1:0]      rd_ptr_q;
  logic [CNT_W-1:0]      count_q;
  logic                  out_valid_q;
  logic [`GW_DATA_W-1:0] out_data_q;
  logic                  push_fire;
  logic                  out_free;
  logic                  bypass;
  logic                  mem_wr;
  logic                  mem_rd;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push_ready_o = (count_q != CNT_W'(DEPTH));
  assign push_fire    = push_valid_i & push_ready_o;

  // Output register takes a new word when empty or being popped
  assign out_free = ~out_valid_q | pop_ready_i;
  assign mem_rd   = out_free & (count_q != '0);
  assign bypass   = out_free & (count_q == '0) & push_fire;
  assign mem_wr   = push_fire & ~bypass;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      count_q     <= '0;
      out_valid_q <= 1'b0;
    end
    else
    begin
      if (mem_wr)
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (mem_rd)
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      if (mem_wr && !mem_rd)
        count_q <= count_q + 1'b1;
      else if (mem_rd && !mem_wr)
        count_q <= count_q - 1'b1;
      if (out_free)
        out_valid_q <= mem_rd | bypass;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (mem_wr)
      mem_q[wr_ptr_q] <= push_data_i;
    if (mem_rd)
      out_data_q <= mem_q[rd_ptr_q];
    else if (bypass)
      out_data_q <= push_data_i;
  end

  assign pop_valid_o = out_valid_q;
  assign pop_data_o  = out_data_q;

endmodule

//--- hw/gw_loopback_top.sv
`timescale 1ns/10ps
`include "gw_defines.svh"

module gw_loopback_top
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 tag_data_i,
  input  logic                 tag_en_i,
  output gw_pkg::node_status_s status_o
);

  gw_pkg::tag_cmd_s      tag_cmd;
  gw_pkg::node_ctrl_s    node_ctrl;
  logic                  inject_ack;
  logic                  push_valid;
  logic [`GW_DATA_W-1:0] push_data;
  logic                  push_ready;
  logic                  pop_valid;
  logic [`GW_DATA_W-1:0] pop_data;
  logic                  pop_ready;

  //////////////////////////////
  // Configuration path
  //////////////////////////////

  gw_tag_master tag_master
  (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .tag_data_i (tag_data_i),
    .tag_en_i   (tag_en_i),
    .cmd_o      (tag_cmd)
  );

  // Registers sit beside the node they steer
  gw_tag_regs tag_regs
  (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cmd_i        (tag_cmd),
    .inject_ack_i (inject_ack),
    .ctrl_o       (node_ctrl)
  );

  //////////////////////////////
  // Node and loopback link
  //////////////////////////////

  gw_test_node node
  (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .ctrl_i       (node_ctrl),
    .inject_ack_o (inject_ack),
    .push_valid_o (push_valid),
    .push_data_o  (push_data),
    .push_ready_i (push_ready),
    .pop_valid_i  (pop_valid),
    .pop_data_i   (pop_data),
    .pop_ready_o  (pop_ready),
    .status_o     (status_o)
  );

  gw_link_fifo #(
    .DEPTH (`GW_FIFO_DEPTH)
  ) link
  (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .push_valid_i (push_valid),
    .push_data_i  (push_data),
    .push_ready_o (push_ready),
    .pop_valid_o  (pop_valid),
    .pop_data_o   (pop_data),
    .pop_ready_i  (pop_ready)
  );

endmodule

//--- hw/gw_pkg.sv
package gw_pkg;

  `include "gw_defines.svh"

  //////////////////////////////
  // Tag line
  //////////////////////////////

  // Client ids carried in the packet header
  typedef enum logic [`GW_TAG_ID_W-1:0] {
    TAG_CTRL,
    TAG_LIMIT,
    TAG_INJECT,
    TAG_SPARE
  } tag_client_e;

  // Deserializer phases
  typedef enum logic [1:0] {
    IDLE,
    ID,
    PAYLOAD
  } tag_rx_state_e;

  // One decoded packet
  typedef struct packed {
    logic                         valid;
    tag_client_e                  client;
    logic [`GW_TAG_PAYLOAD_W-1:0] payload;
  } tag_cmd_s;

  //////////////////////////////
  // Test node
  //////////////////////////////

  // Register bank to node
  typedef struct packed {
    logic                 enable;
    logic                 soft_reset;
    logic [`GW_CNT_W-1:0] limit;
    logic [`GW_DATA_W-1:0] inject_mask;
    logic                 inject_req;
  } node_ctrl_s;

  // Node counters seen at the top level
  typedef struct packed {
    logic [`GW_CNT_W-1:0] sent;
    logic [`GW_CNT_W-1:0] received;
    logic [`GW_CNT_W-1:0] errors;
    logic                 error_flag;
  } node_status_s;

endpackage

//--- hw/gw_tag_master.sv
`timescale 1ns/10ps
`include "gw_defines.svh"

module gw_tag_master
(
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             tag_data_i,
  input  logic             tag_en_i,
  output gw_pkg::tag_cmd_s cmd_o
);

  localparam int ID_W    = `GW_TAG_ID_W;
  localparam int PLD_W   = `GW_TAG_PAYLOAD_W;
  localparam int SHIFT_W = ID_W + PLD_W;
  localparam int CNT_W   = $clog2(PLD_W);

  gw_pkg::tag_rx_state_e state_q;
  gw_pkg::tag_rx_state_e state_d;
  logic [CNT_W-1:0]      bit_cnt_q;
  logic [CNT_W-1:0]      bit_cnt_d;
  logic [SHIFT_W-1:0]    shift_q;
  logic [SHIFT_W-1:0]    shift_next;
  logic                  pkt_done;
  logic                  cmd_valid_q;
  logic [SHIFT_W-1:0]    cmd_word_q;

  // Id bits first, then payload, both MSB first
  assign shift_next = {shift_q[SHIFT_W-2:0], tag_data_i};

  //////////////////////////////
  // Packet FSM
  //////////////////////////////

  always_comb
  begin
    state_d   = state_q;
    bit_cnt_d = bit_cnt_q;
    pkt_done  = 1'b0;
    // Disabled cycles leave everything untouched
    if (tag_en_i)
    begin
      case (state_q)
        gw_pkg::IDLE:
        begin
          if (tag_data_i)
          begin
            state_d   = gw_pkg::ID;
            bit_cnt_d = '0;
          end
        end
        gw_pkg::ID:
        begin
          if (bit_cnt_q == CNT_W'(ID_W - 1))
          begin
            state_d   = gw_pkg::PAYLOAD;
            bit_cnt_d = '0;
          end
          else
            bit_cnt_d = bit_cnt_q + 1'b1;
        end
        gw_pkg::PAYLOAD:
        begin
          if (bit_cnt_q == CNT_W'(PLD_W - 1))
          begin
            state_d  = gw_pkg::IDLE;
            pkt_done = 1'b1;
          end
          else
            bit_cnt_d = bit_cnt_q + 1'b1;
        end
        default: state_d = gw_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q     <= gw_pkg::IDLE;
      bit_cnt_q   <= '0;
      cmd_valid_q <= 1'b0;
    end
    else
    begin
      state_q     <= state_d;
      bit_cnt_q   <= bit_cnt_d;
      cmd_valid_q <= pkt_done;
    end
  end

  // Start bit is not kept
  always_ff @(posedge clk_i)
  begin
    if (tag_en_i && state_q != gw_pkg::IDLE)
      shift_q <= shift_next;
    if (pkt_done)
      cmd_word_q <= shift_next;
  end

  assign cmd_o.valid   = cmd_valid_q;
  assign cmd_o.client  = gw_pkg::tag_client_e'(cmd_word_q[SHIFT_W-1 -: ID_W]);
  assign cmd_o.payload = cmd_word_q[PLD_W-1:0];

endmodule

//--- hw/gw_tag_regs.sv
`timescale 1ns/10ps
`include "gw_defines.svh"

module gw_tag_regs
(
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  gw_pkg::tag_cmd_s   cmd_i,
  input  logic               inject_ack_i,
  output gw_pkg::node_ctrl_s ctrl_o
);

  localparam int LIMIT_PAD_W = `GW_CNT_W - `GW_TAG_PAYLOAD_W;

  gw_pkg::node_ctrl_s ctrl_q;
  logic               wr_ctrl;
  logic               wr_limit;
  logic               wr_inject;

  // Client decode
  always_comb
  begin
    wr_ctrl   = 1'b0;
    wr_limit  = 1'b0;
    wr_inject = 1'b0;
    if (cmd_i.valid)
    begin
      case (cmd_i.client)
        gw_pkg::TAG_CTRL:   wr_ctrl   = 1'b1;
        gw_pkg::TAG_LIMIT:  wr_limit  = 1'b1;
        gw_pkg::TAG_INJECT: wr_inject = 1'b1;
        // Spare client owns no register
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      ctrl_q <= '0;
    else
    begin
      // Soft reset lasts one cycle
      ctrl_q.soft_reset <= 1'b0;
      if (wr_ctrl)
      begin
        ctrl_q.enable     <= cmd_i.payload[0];
        ctrl_q.soft_reset <= cmd_i.payload[1];
      end
      if (wr_limit)
        ctrl_q.limit <= {{LIMIT_PAD_W{1'b0}}, cmd_i.payload};
      // A new inject write wins over a same-cycle ack
      if (wr_inject)
      begin
        ctrl_q.inject_mask <= cmd_i.payload;
        ctrl_q.inject_req  <= 1'b1;
      end
      else if (inject_ack_i)
        ctrl_q.inject_req <= 1'b0;
    end
  end

  assign ctrl_o = ctrl_q;

endmodule

//--- hw/gw_test_node.sv
`timescale 1ns/10ps
`include "gw_defines.svh"

module gw_test_node
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  gw_pkg::node_ctrl_s    ctrl_i,
  output logic                  inject_ack_o,
  output logic                  push_valid_o,
  output logic [`GW_DATA_W-1:0] push_data_o,
  input  logic                  push_ready_i,
  input  logic                  pop_valid_i,
  input  logic [`GW_DATA_W-1:0] pop_data_i,
  output logic                  pop_ready_o,
  output gw_pkg::node_status_s  status_o
);

  localparam int DATA_W = `GW_DATA_W;

  logic [DATA_W-1:0]    tx_lfsr_q;
  logic [DATA_W-1:0]    tx_next;
  logic [DATA_W-1:0]    rx_lfsr_q;
  logic [DATA_W-1:0]    rx_expect;
  logic [`GW_CNT_W-1:0] sent_q;
  logic [`GW_CNT_W-1:0] received_q;
  logic [`GW_CNT_W-1:0] errors_q;
  logic                 error_flag_q;
  logic                 send_ok;
  logic                 push_fire;
  logic                 pop_fire;
  logic                 mismatch;

  // Fibonacci LFSR, taps 8 6 5 4
  function automatic logic [DATA_W-1:0] lfsr_step(input logic [DATA_W-1:0] q);
    return {q[DATA_W-2:0], q[7] ^ q[5] ^ q[4] ^ q[3]};
  endfunction

  //////////////////////////////
  // Sender
  //////////////////////////////

  assign send_ok      = ctrl_i.enable & ~ctrl_i.soft_reset & (sent_q < ctrl_i.limit);
  assign tx_next      = lfsr_step(tx_lfsr_q);
  assign push_valid_o = send_ok;
  // Mask only corrupts the link word, never the LFSR
  assign push_data_o  = tx_next ^ (ctrl_i.inject_req ? ctrl_i.inject_mask : '0);
  assign push_fire    = send_ok & push_ready_i;
  assign inject_ack_o = push_fire & ctrl_i.inject_req;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      tx_lfsr_q <= `GW_LFSR_SEED;
      sent_q    <= '0;
    end
    else if (ctrl_i.soft_reset)
    begin
      tx_lfsr_q <= `GW_LFSR_SEED;
      sent_q    <= '0;
    end
    else if (push_fire)
    begin
      tx_lfsr_q <= tx_next;
      sent_q    <= sent_q + 1'b1;
    end
  end

  //////////////////////////////
  // Receiver and checker
  //////////////////////////////

  assign pop_ready_o = 1'b1;
  assign pop_fire    = pop_valid_i & pop_ready_o & ~ctrl_i.soft_reset;
  assign rx_expect   = lfsr_step(rx_lfsr_q);
  assign mismatch    = pop_fire & (pop_data_i != rx_expect);

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      rx_lfsr_q    <= `GW_LFSR_SEED;
      received_q   <= '0;
      errors_q     <= '0;
      error_flag_q <= 1'b0;
    end
    else if (ctrl_i.soft_reset)
    begin
      rx_lfsr_q    <= `GW_LFSR_SEED;
      received_q   <= '0;
      errors_q     <= '0;
      error_flag_q <= 1'b0;
    end
    else if (pop_fire)
    begin
      rx_lfsr_q  <= rx_expect;
      received_q <= received_q + 1'b1;
      if (mismatch)
      begin
        errors_q     <= errors_q + 1'b1;
        // Sticky until soft reset
        error_flag_q <= 1'b1;
      end
    end
  end

  assign status_o.sent       = sent_q;
  assign status_o.received   = received_q;
  assign status_o.errors     = errors_q;
  assign status_o.error_flag = error_flag_q;

endmodule

//--- tb/gw_loopback_chk.sv
`timescale 1ns/10ps
`include "gw_defines.svh"

module gw_loopback_chk
(
  input logic                  clk_i,
  input logic                  rst_n_i,
  input gw_pkg::node_status_s  status_i,
  input logic                  push_valid_i,
  input logic                  push_ready_i,
  input logic [`GW_DATA_W-1:0] push_data_i,
  input logic                  cmd_valid_i
);

  //////////////////////////////
  // Counter relations
  //////////////////////////////

  // Nothing comes back that was not sent
  rx_le_tx: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    status_i.received <= status_i.sent)
    else $error("received count ran ahead of sent count");

  //////////////////////////////
  // Link and tag handshakes
  //////////////////////////////

  // Word refused by a full FIFO is offered again unchanged
  push_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_valid_i && !push_ready_i |=> push_valid_i && $stable(push_data_i))
    else $error("push word dropped or changed while FIFO was full");

  cmd_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cmd_valid_i |=> !cmd_valid_i)
    else $error("tag command valid held for two cycles");

endmodule

bind gw_loopback_top gw_loopback_chk chk0
(
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .status_i     (status_o),
  .push_valid_i (push_valid),
  .push_ready_i (push_ready),
  .push_data_i  (push_data),
  .cmd_valid_i  (tag_cmd.valid)
);

//--- tb/tb_gw_loopback.sv
`timescale 1ns/10ps
`include "gw_defines.svh"

module tb_gw_loopback;

  localparam int CLK_PERIOD  = 20;
  localparam int PKT_BITS    = 1 + `GW_TAG_ID_W + `GW_TAG_PAYLOAD_W;
  localparam int MIN_LIMIT   = 40;
  localparam int MAX_LIMIT   = MIN_LIMIT + 127;
  localparam int NUM_TESTS   = 6;
  localparam int WATCHDOG_NS =
    NUM_TESTS * MAX_LIMIT * (PKT_BITS + `GW_FIFO_DEPTH) * CLK_PERIOD + 20000;

  logic                 clk;
  logic                 rst_n;
  logic                 tag_data;
  logic                 tag_en;
  gw_pkg::node_status_s status;

  logic [31:0]          lfsr_state = 32'd88714;
  gw_pkg::node_status_s exp_q;
  logic                 check_req = 1'b0;
  logic                 check_done = 1'b0;
  int                   err_cnt = 0;
  int                   check_cnt = 0;
  int                   test_cnt = 0;
  int                   test_fail_cnt = 0;
  int                   test_err_mark = 0;

  gw_loopback_top dut0
  (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .tag_data_i (tag_data),
    .tag_en_i   (tag_en),
    .status_o   (status)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////
  // Random numbers and model
  //////////////////////////////

  // 32-bit Fibonacci LFSR on taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    int          i;
    r = '0;
    for (i = 0; i < n; i++)
    begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r          = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [15:0] new_limit();
    return 16'(MIN_LIMIT) + 16'(rand_bits(7));
  endfunction

  // Expected counters for a finished run of the programmed state
  function automatic gw_pkg::node_status_s expect_status(input logic        enable,
                                                         input logic [15:0] limit,
                                                         input logic [7:0]  mask);
    gw_pkg::node_status_s s;
    s = '0;
    if (enable && limit != 16'd0)
    begin
      s.sent     = limit;
      s.received = limit;
      // A pending mask corrupts exactly one word of the run
      if (mask != 8'd0)
      begin
        s.errors     = 16'd1;
        s.error_flag = 1'b1;
      end
    end
    return s;
  endfunction

  //////////////////////////////
  // Stimulus tasks
  //////////////////////////////

  task automatic send_tag(input gw_pkg::tag_client_e client, input logic [7:0] payload,
                          input bit gaps);
    logic [PKT_BITS-1:0] pkt;
    int                  i;
    int                  idle;
    pkt = {1'b1, client, payload};
    for (i = PKT_BITS - 1; i >= 0; i--)
    begin
      idle = gaps ? int'(rand_bits(2)) : 0;
      // Junk on the data line while disabled
      repeat (idle)
      begin
        @(posedge clk);
        tag_en   <= 1'b0;
        tag_data <= (rand_bits(1) != 0);
      end
      @(posedge clk);
      tag_en   <= 1'b1;
      tag_data <= pkt[i];
    end
    @(posedge clk);
    tag_en   <= 1'b0;
    tag_data <= 1'b0;
    // Register update two cycles after the last bit
    repeat (2) @(posedge clk);
  endtask

  task automatic run_check(input gw_pkg::node_status_s exp);
    exp_q     = exp;
    check_req = 1'b1;
    wait (check_done);
    check_req = 1'b0;
    wait (!check_done);
  endtask

  task automatic report_test(input string name);
    test_cnt++;
    if (err_cnt == test_err_mark)
      $display("test %0d %s: ok", test_cnt, name);
    else
    begin
      test_fail_cnt++;
      $display("test %0d %s: %0d mismatches", test_cnt, name, err_cnt - test_err_mark);
    end
    test_err_mark = err_cnt;
  endtask

  //////////////////////////////
  // Comparison
  //////////////////////////////

  always
  begin : compare_proc
    wait (check_req);
    @(negedge clk);
    while (status.received != exp_q.received)
      @(negedge clk);
    // Words beyond the limit would show up within a few more cycles
    repeat (`GW_FIFO_DEPTH + 2) @(negedge clk);
    check_cnt++;
    assert (status.sent == exp_q.sent)
    else
    begin
      $display("FAIL status_o.sent expected %h got %h", exp_q.sent, status.sent);
      err_cnt++;
    end
    assert (status.received == exp_q.received)
    else
    begin
      $display("FAIL status_o.received expected %h got %h", exp_q.received, status.received);
      err_cnt++;
    end
    assert (status.errors == exp_q.errors)
    else
    begin
      $display("FAIL status_o.errors expected %h got %h", exp_q.errors, status.errors);
      err_cnt++;
    end
    assert (status.error_flag == exp_q.error_flag)
    else
    begin
      $display("FAIL status_o.error_flag expected %h got %h", exp_q.error_flag,
               status.error_flag);
      err_cnt++;
    end
    check_done = 1'b1;
    wait (!check_req);
    check_done = 1'b0;
  end

  initial
  begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Something failed");
    $finish;
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial
  begin : stimulus
    logic [15:0] limit;
    logic [7:0]  mask;
    rst_n    <= 1'b0;
    tag_data <= 1'b0;
    tag_en   <= 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // Idle after reset, then a limit with enable low
    run_check(expect_status(1'b0, 16'd0, 8'd0));
    limit = new_limit();
    send_tag(gw_pkg::TAG_LIMIT, limit[7:0], 1'b0);
    repeat (20) @(posedge clk);
    run_check(expect_status(1'b0, limit, 8'd0));
    report_test("reset_idle");

    send_tag(gw_pkg::TAG_CTRL, 8'h01, 1'b0);
    run_check(expect_status(1'b1, limit, 8'd0));
    report_test("basic_run");

    // Fresh counters, then an inject packet while the run is going
    send_tag(gw_pkg::TAG_CTRL, 8'h02, 1'b0);
    limit = new_limit();
    mask  = 8'(rand_bits(8));
    if (mask == 8'd0)
      mask = 8'h01;
    send_tag(gw_pkg::TAG_LIMIT, limit[7:0], 1'b0);
    send_tag(gw_pkg::TAG_CTRL, 8'h01, 1'b0);
    send_tag(gw_pkg::TAG_INJECT, mask, 1'b0);
    run_check(expect_status(1'b1, limit, mask));
    report_test("inject");

    send_tag(gw_pkg::TAG_CTRL, 8'h02, 1'b0);
    run_check(expect_status(1'b0, limit, 8'd0));
    limit = new_limit();
    send_tag(gw_pkg::TAG_LIMIT, limit[7:0], 1'b0);
    send_tag(gw_pkg::TAG_CTRL, 8'h01, 1'b0);
    run_check(expect_status(1'b1, limit, 8'd0));
    report_test("soft_reset_rerun");

    send_tag(gw_pkg::TAG_CTRL, 8'h02, 1'b1);
    limit = new_limit();
    send_tag(gw_pkg::TAG_LIMIT, limit[7:0], 1'b1);
    send_tag(gw_pkg::TAG_CTRL, 8'h01, 1'b1);
    run_check(expect_status(1'b1, limit, 8'd0));
    report_test("gapped_packets");

    // Spare payload looks like a soft reset if misdecoded
    mask = 8'(rand_bits(8));
    send_tag(gw_pkg::TAG_SPARE, mask | 8'h03, 1'b0);
    repeat (20) @(posedge clk);
    run_check(expect_status(1'b1, limit, 8'd0));
    report_test("spare_client");

    $display("Tests: %0d run, %0d failed; checks: %0d; mismatches: %0d",
             test_cnt, test_fail_cnt, check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule
